/* source/mmioPkg.sv */
package mmioPkg;

	// response code as seen by the requester
	typedef enum logic [1:0] {
		OkReady = 2'd0,
		OkOk    = 2'd1,
		OkHold  = 2'd2,
		OkFault = 2'd3
	} okCode_t;

	// other nonzero codes are operations no block serves
	typedef enum logic [4:0] {
		OpmNone  = 5'h00,
		OpmRead  = 5'h01,
		OpmWrite = 5'h02
	} opm_t;

	typedef struct packed {
		logic [31:0] addr;
		opm_t        opm;
		logic [63:0] wdata;
	} mmioReq_t;

	typedef struct packed {
		logic [63:0] data;
		okCode_t     ok;
	} mmioResp_t;

	// bus exception word, info is left at zero here
	typedef struct packed {
		logic [15:0] code;
		logic [47:0] info;
	} busExc_t;

	localparam logic [15:0] ExcTimer = 16'hC001;

	// default register windows, 16 bytes each
	localparam logic [31:0] DefaultGpioBase  = 32'hF000_E000;
	localparam logic [31:0] DefaultTimerBase = 32'hF000_E100;

	// cycles before an unclaimed request is answered
	localparam logic [5:0] DefaultMissLimit = 6'd15;

endpackage

/* source/tickPrescaler.sv */
`timescale 1ns/1ps

module tickPrescaler #(
	parameter int UsDivide = 100,
	parameter int MsDivide = 1000
) (
	input  logic clock,
	input  logic reset_i,
	output logic usTick_o,
	output logic msTick_o
);

	localparam int UsWidth = $clog2(UsDivide + 1);
	localparam int MsWidth = $clog2(MsDivide + 1);

	logic [UsWidth-1:0] usCount;
	logic [MsWidth-1:0] msCount;

	// microsecond divider, msTick rides on the usTick that closes a period
	always_ff @(posedge clock)
	begin
		if (reset_i)
		begin
			usCount  <= '0;
			msCount  <= '0;
			usTick_o <= 1'b0;
			msTick_o <= 1'b0;
		end
		else if (usCount == UsWidth'(UsDivide - 1))
		begin
			usCount  <= '0;
			usTick_o <= 1'b1;
			if (msCount == MsWidth'(MsDivide - 1))
			begin
				msCount  <= '0;
				msTick_o <= 1'b1;
			end
			else
			begin
				msCount  <= msCount + 1'b1;
				msTick_o <= 1'b0;
			end
		end
		else
		begin
			usCount  <= usCount + 1'b1;
			usTick_o <= 1'b0;
			msTick_o <= 1'b0;
		end
	end

endmodule

/* source/gpioRegs.sv */
`timescale 1ns/1ps

module gpioRegs import mmioPkg::*; #(
	parameter logic [31:0] BaseAddr = DefaultGpioBase
) (
	input  logic        clock,
	input  logic        reset_i,
	input  mmioReq_t    req_i,
	input  logic [31:0] pins_i,
	output mmioResp_t   resp_o,
	output logic [31:0] pins_o
);

	localparam logic [3:0] OffOut = 4'h0;
	localparam logic [3:0] OffIn  = 4'h4;

	logic [31:0] pinsMeta;
	logic [31:0] pinsSync;
	logic [31:0] outReg;
	logic        inWindow;
	logic        validOp;
	logic        isWrite;
	logic        hit;
	logic        accept;
	logic [31:0] readData;
	okCode_t     okQ;
	logic [63:0] dataQ;

	// only the two registers are claimed, the rest of the window misses
	assign inWindow = req_i.addr[31:4] == BaseAddr[31:4];
	assign validOp  = (req_i.opm == OpmRead) || (req_i.opm == OpmWrite);
	assign isWrite  = req_i.opm == OpmWrite;
	assign hit      = inWindow && validOp
		&& ((req_i.addr[3:0] == OffOut) || (req_i.addr[3:0] == OffIn));

	// first cycle of a request, later cycles only hold the answer
	assign accept = hit && (okQ == OkReady);

	always_comb
	begin
		if (req_i.addr[3:0] == OffIn)
			readData = pinsSync;
		else
			readData = outReg;
	end

	// two-stage resample of the pin inputs
	always_ff @(posedge clock)
	begin
		pinsMeta <= pins_i;
		pinsSync <= pinsMeta;
	end

	always_ff @(posedge clock)
	begin
		if (reset_i)
		begin
			okQ    <= OkReady;
			outReg <= '0;
		end
		else if (accept)
		begin
			okQ <= OkOk;
			// input register ignores writes
			if (isWrite && (req_i.addr[3:0] == OffOut))
				outReg <= req_i.wdata[31:0];
		end
		else if (!hit)
			okQ <= OkReady;
	end

	always_ff @(posedge clock)
	begin
		if (accept)
			dataQ <= {32'h0, readData};
	end

	assign resp_o = '{data: dataQ, ok: okQ};
	assign pins_o = outReg;

endmodule

/* source/timerRegs.sv */
`timescale 1ns/1ps

module timerRegs import mmioPkg::*; #(
	parameter logic [31:0] BaseAddr = DefaultTimerBase
) (
	input  logic      clock,
	input  logic      reset_i,
	input  mmioReq_t  req_i,
	input  logic      usTick_i,
	input  logic      msTick_i,
	output mmioResp_t resp_o,
	output busExc_t   busExc_o
);

	localparam logic [3:0] OffCount = 4'h0;
	localparam logic [3:0] OffCtrl  = 4'h8;

	logic [63:0] usCount;
	logic        irqEnable;
	logic        inWindow;
	logic        validOp;
	logic        isWrite;
	logic        hit;
	logic        accept;
	logic [63:0] readData;
	okCode_t     okQ;
	logic [63:0] dataQ;
	busExc_t     busExcQ;

	assign inWindow = req_i.addr[31:4] == BaseAddr[31:4];
	assign validOp  = (req_i.opm == OpmRead) || (req_i.opm == OpmWrite);
	assign isWrite  = req_i.opm == OpmWrite;
	assign hit      = inWindow && validOp
		&& ((req_i.addr[3:0] == OffCount) || (req_i.addr[3:0] == OffCtrl));
	assign accept   = hit && (okQ == OkReady);

	always_comb
	begin
		if (req_i.addr[3:0] == OffCtrl)
			readData = {63'h0, irqEnable};
		else
			readData = usCount;
	end

	// free-running microsecond count
	always_ff @(posedge clock)
	begin
		if (reset_i)
			usCount <= '0;
		else if (usTick_i)
			usCount <= usCount + 64'd1;
	end

	// bus handshake and control register, counter is read only
	always_ff @(posedge clock)
	begin
		if (reset_i)
		begin
			okQ       <= OkReady;
			irqEnable <= 1'b0;
		end
		else if (accept)
		begin
			okQ <= OkOk;
			if (isWrite && (req_i.addr[3:0] == OffCtrl))
				irqEnable <= req_i.wdata[0];
		end
		else if (!hit)
			okQ <= OkReady;
	end

	always_ff @(posedge clock)
	begin
		if (accept)
			dataQ <= readData;
	end

	// one-cycle exception after each millisecond tick
	always_ff @(posedge clock)
	begin
		if (reset_i)
			busExcQ <= '0;
		else if (msTick_i && irqEnable)
			busExcQ <= '{code: ExcTimer, info: 48'h0};
		else
			busExcQ <= '0;
	end

	assign resp_o   = '{data: dataQ, ok: okQ};
	assign busExc_o = busExcQ;

endmodule

/* source/mmioRespMux.sv */
`timescale 1ns/1ps

module mmioRespMux import mmioPkg::*; #(
	parameter logic [5:0] MissLimit = DefaultMissLimit
) (
	input  logic      clock,
	input  logic      reset_i,
	input  opm_t      reqOpm_i,
	input  mmioResp_t gpioResp_i,
	input  mmioResp_t timerResp_i,
	output mmioResp_t resp_o,
	output logic      missSeen_o
);

	logic [5:0] missCnt;
	logic [5:0] missCntNext;
	logic       missHit;
	logic       missSeen;

	// gpio has priority over the timer
	always_comb
	begin
		resp_o      = '{data: 64'h0, ok: OkReady};
		missCntNext = '0;
		missHit     = 1'b0;

		if (gpioResp_i.ok != OkReady)
			resp_o = gpioResp_i;
		else if (timerResp_i.ok != OkReady)
			resp_o = timerResp_i;
		else if (reqOpm_i != OpmNone)
		begin
			// unclaimed request answered with zero data at the limit
			if (missCnt == MissLimit)
			begin
				missCntNext = missCnt;
				resp_o.data = 64'h0;
				resp_o.ok   = OkOk;
			end
			else
				missCntNext = missCnt + 6'd1;
			// flag rises together with the answer
			missHit = missCntNext == MissLimit;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset_i)
		begin
			missCnt  <= '0;
			missSeen <= 1'b0;
		end
		else
		begin
			missCnt <= missCntNext;
			// sticky until the next reset
			if (missHit)
				missSeen <= 1'b1;
		end
	end

	assign missSeen_o = missSeen;

endmodule

/* source/mmioSubsystem.sv */
`timescale 1ns/1ps

module mmioSubsystem import mmioPkg::*; #(
	parameter int          UsDivide  = 100,
	parameter int          MsDivide  = 1000,
	parameter logic [31:0] GpioBase  = DefaultGpioBase,
	parameter logic [31:0] TimerBase = DefaultTimerBase,
	parameter logic [5:0]  MissLimit = DefaultMissLimit
) (
	input  logic        clock,
	input  logic        reset_i,
	input  mmioReq_t    req_i,
	output mmioResp_t   resp_o,
	input  logic [31:0] gpioPins_i,
	output logic [31:0] gpioPins_o,
	output busExc_t     busExc_o,
	output logic        missSeen_o
);

	logic      usTick;
	logic      msTick;
	mmioResp_t gpioResp;
	mmioResp_t timerResp;

	tickPrescaler #(
		.UsDivide(UsDivide),
		.MsDivide(MsDivide)
	) u_prescaler (
		.clock   (clock),
		.reset_i (reset_i),
		.usTick_o(usTick),
		.msTick_o(msTick)
	);

	gpioRegs #(
		.BaseAddr(GpioBase)
	) u_gpio (
		.clock  (clock),
		.reset_i(reset_i),
		.req_i  (req_i),
		.pins_i (gpioPins_i),
		.resp_o (gpioResp),
		.pins_o (gpioPins_o)
	);

	timerRegs #(
		.BaseAddr(TimerBase)
	) u_timer (
		.clock   (clock),
		.reset_i (reset_i),
		.req_i   (req_i),
		.usTick_i(usTick),
		.msTick_i(msTick),
		.resp_o  (timerResp),
		.busExc_o(busExc_o)
	);

	// the miss timeout only needs the operation code
	mmioRespMux #(
		.MissLimit(MissLimit)
	) u_respMux (
		.clock      (clock),
		.reset_i    (reset_i),
		.reqOpm_i   (req_i.opm),
		.gpioResp_i (gpioResp),
		.timerResp_i(timerResp),
		.resp_o     (resp_o),
		.missSeen_o (missSeen_o)
	);

endmodule

/* verification/mmioBus_properties.sv */
`timescale 1ns/1ps

module mmioBusProperties import mmioPkg::*; (
	input logic      clock,
	input logic      reset_i,
	input mmioResp_t resp_i,
	input mmioResp_t gpioResp_i,
	input mmioResp_t timerResp_i,
	input busExc_t   busExc_i
);

	logic missAnswer;

	// an OkOk that neither peripheral gave comes from the miss timeout
	assign missAnswer = (resp_i.ok == OkOk) && (gpioResp_i.ok == OkReady)
		&& (timerResp_i.ok == OkReady);

	respCodeLegal: assert property (@(posedge clock) disable iff (reset_i)
		(resp_i.ok == OkReady) || (resp_i.ok == OkOk))
	else
		$error("response code %0d is neither OkReady nor OkOk", resp_i.ok);

	excSingleCycle: assert property (@(posedge clock) disable iff (reset_i)
		(busExc_i != '0) |=> (busExc_i == '0))
	else
		$error("bus exception held for more than one cycle");

	missDataZero: assert property (@(posedge clock) disable iff (reset_i)
		missAnswer |-> (resp_i.data == 64'h0))
	else
		$error("miss answer carries nonzero data 0x%0h", resp_i.data);

endmodule

bind mmioSubsystem mmioBusProperties u_busProperties (
	.clock      (clock),
	.reset_i    (reset_i),
	.resp_i     (resp_o),
	.gpioResp_i (gpioResp),
	.timerResp_i(timerResp),
	.busExc_i   (busExc_o)
);

/* verification/mmioTests.svh */
// one request on the bus from raising opm to the idle answer after release
task automatic busAccess(input opm_t opm, input logic [31:0] addr, input logic [63:0] wdata,
	input int hold, output logic [63:0] rdata, output int cycles);
	req = '{addr: addr, opm: opm, wdata: wdata};
	nextCycle();
	cycles = 1;
	while (resp.ok != OkOk)
	begin
		if (cycles >= RespLimit)
			failRun($sformatf("no OkOk for opm %0d at address 0x%08h within %0d cycles",
				opm, addr, RespLimit));
		nextCycle();
		cycles++;
	end
	rdata = resp.data;
	// a held request keeps the same answer
	repeat (hold)
	begin
		nextCycle();
		checkEqual("resp_o.ok while held", resp.ok, OkOk);
		checkEqual("resp_o.data while held", resp.data, rdata);
	end
	req.opm = OpmNone;
	nextCycle();
	checkEqual("resp_o.ok after release", resp.ok, OkReady);
endtask

task automatic busWrite(input logic [31:0] addr, input logic [63:0] wdata, input int hold);
	logic [63:0] rdata;
	int          cycles;
	busAccess(OpmWrite, addr, wdata, hold, rdata, cycles);
	checkEqual("write response cycles", cycles, 1);
endtask

task automatic busRead(input logic [31:0] addr, input int hold, output logic [63:0] rdata,
	output int cycles);
	busAccess(OpmRead, addr, 64'h0, hold, rdata, cycles);
endtask

task automatic testResetState();
	checkEqual("resp_o.ok", resp.ok, OkReady);
	checkEqual("gpioPins_o", pinsOut, 32'h0);
	checkEqual("busExc_o", busExc, 64'h0);
	checkEqual("missSeen_o", missSeen, 1'b0);
endtask

task automatic testGpioRegister();
	logic [63:0] wdata;
	logic [63:0] rdata;
	int          cycles;
	repeat (3)
	begin
		wdata = {$random(seed), $random(seed)};
		busWrite(DefaultGpioBase, wdata, 0);
		checkEqual("gpioPins_o", pinsOut, wdata[31:0]);
		busRead(DefaultGpioBase, 0, rdata, cycles);
		checkEqual("gpio output read", rdata, {32'h0, wdata[31:0]});
		checkEqual("gpio read cycles", cycles, 1);
	end
	pinsIn = $random(seed);
	repeat (3) nextCycle();
	busRead(DefaultGpioBase + 32'h4, 0, rdata, cycles);
	checkEqual("gpio input read", rdata, {32'h0, pinsIn});
	wdata = {32'h0, $random(seed)};
	busWrite(DefaultGpioBase, wdata, 3);
	checkEqual("gpioPins_o after held write", pinsOut, wdata[31:0]);
	busRead(DefaultGpioBase, 3, rdata, cycles);
	checkEqual("gpio output read after held write", rdata, wdata);
	lastGpio = wdata[31:0];
endtask

task automatic testMicrosecondCounter();
	logic [63:0] first;
	logic [63:0] second;
	logic [63:0] delta;
	logic [63:0] bounded;
	int          cycles;
	int          startCycle;
	int          gap;
	int          minGap;
	minGap = 40;
	busRead(DefaultTimerBase, 0, first, cycles);
	startCycle = cycleCount;
	repeat (minGap) nextCycle();
	busRead(DefaultTimerBase, 0, second, cycles);
	gap   = cycleCount - startCycle;
	delta = second - first;
	// one tick every UsDiv cycles give or take one at each end
	bounded = delta;
	if (delta < minGap / UsDiv - 1)
		bounded = minGap / UsDiv - 1;
	else if (delta > gap / UsDiv + 1)
		bounded = gap / UsDiv + 1;
	checkEqual("timer count delta", delta, bounded);
endtask

task automatic testTimerException();
	logic [63:0] rdata;
	int          cycles;
	int          pulses;
	repeat (60)
	begin
		nextCycle();
		checkEqual("busExc_o with enable clear", busExc, 64'h0);
	end
	busWrite(DefaultTimerBase + 32'h8, 64'h1, 0);
	busRead(DefaultTimerBase + 32'h8, 0, rdata, cycles);
	checkEqual("timer control read", rdata, 64'h1);
	pulses = 0;
	repeat (60)
	begin
		nextCycle();
		if (busExc != '0)
		begin
			pulses++;
			checkEqual("busExc_o.code", busExc.code, 16'hC001);
			checkEqual("busExc_o.info", busExc.info, 48'h0);
		end
	end
	checkEqual("timer exception pulses", pulses, (pulses < 2) ? 2 : pulses);
	busWrite(DefaultTimerBase + 32'h8, 64'h0, 0);
endtask

task automatic testBusMiss();
	logic [63:0] rdata;
	int          cycles;
	busRead(32'h1000_0000, 0, rdata, cycles);
	checkEqual("miss response cycles", cycles, MissLimit);
	checkEqual("miss read data", rdata, 64'h0);
	checkEqual("missSeen_o", missSeen, 1'b1);
	busRead(DefaultGpioBase, 0, rdata, cycles);
	checkEqual("gpio read cycles after miss", cycles, 1);
	checkEqual("gpio output read after miss", rdata, {32'h0, lastGpio});
endtask

/* verification/mmioSubsystemTb.sv */
`timescale 1ns/1ps

module mmioSubsystemTb import mmioPkg::*; ();

	localparam int         UsDiv      = 4;
	localparam int         MsDiv      = 5;
	localparam logic [5:0] MissLimit  = 6'd15;
	localparam int         RespLimit  = MissLimit + 4;
	localparam int         DriveDelay = 5;
	// the whole sequence needs a few hundred cycles
	localparam int         CycleLimit = 2000;

	logic        clock;
	logic        reset;
	mmioReq_t    req;
	mmioResp_t   resp;
	logic [31:0] pinsIn;
	logic [31:0] pinsOut;
	busExc_t     busExc;
	logic        missSeen;
	integer      seed;
	int          cycleCount;
	logic [31:0] lastGpio;

	mmioSubsystem #(
		.UsDivide (UsDiv),
		.MsDivide (MsDiv),
		.GpioBase (DefaultGpioBase),
		.TimerBase(DefaultTimerBase),
		.MissLimit(MissLimit)
	) u_dut (
		.clock     (clock),
		.reset_i   (reset),
		.req_i     (req),
		.resp_o    (resp),
		.gpioPins_i(pinsIn),
		.gpioPins_o(pinsOut),
		.busExc_o  (busExc),
		.missSeen_o(missSeen)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock;
	end

	// watchdog on the total run length
	initial
	begin
		cycleCount = 0;
		while (cycleCount < CycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		failRun($sformatf("timeout: tests still running after %0d cycles", CycleLimit));
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic checkEqual(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
			failRun($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected));
	endtask

	// inputs change and outputs are sampled a little after each rising edge
	task automatic nextCycle();
		@(posedge clock);
		#DriveDelay;
	endtask

	`include "mmioTests.svh"

	initial
	begin
		seed     = 32'h41a55745;
		reset    = 1'b1;
		req      = '{addr: 32'h0, opm: OpmNone, wdata: 64'h0};
		pinsIn   = 32'h0;
		lastGpio = 32'h0;
		repeat (4) @(posedge clock);
		#DriveDelay;
		reset = 1'b0;

		testResetState();
		testGpioRegister();
		testMicrosecondCounter();
		testTimerException();
		testBusMiss();

		$display("** PASS **");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+verification
source/mmioPkg.sv
source/tickPrescaler.sv
source/gpioRegs.sv
source/timerRegs.sv
source/mmioRespMux.sv
source/mmioSubsystem.sv
verification/mmioBus_properties.sv
verification/mmioSubsystemTb.sv

/* Bender.yml */
package:
  name: mmio_subsystem

sources:
  - files:
      - source/mmioPkg.sv
      - source/tickPrescaler.sv
      - source/gpioRegs.sv
      - source/timerRegs.sv
      - source/mmioRespMux.sv
      - source/mmioSubsystem.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/mmioBus_properties.sv
      - verification/mmioSubsystemTb.sv
